/* verilog.f */
+incdir+verilog
verilog/mipsPkg.sv
verilog/instructionFetch.sv
verilog/instructionDecode.sv
verilog/execute.sv
verilog/memoryAccess.sv
verilog/mipsPipeline.sv
tests/writeBackChecker.sv
tests/mipsPipelineTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module mipsPipelineTb -f verilog.f -o mipsPipelineSim
output=$(./obj_dir/mipsPipelineSim)
echo "$output"
if echo "$output" | grep -qx "Result: PASSED"; then
	exit 0
fi
exit 1

/* tests/mipsPipelineTb.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module mipsPipelineTb;
	import mipsPkg::*;

	logic        clk;
	logic        reset;
	logic        run;
	logic        loadProgram;
	word         programAddress;
	word         programInstruction;
	logic        writeInstruction;
	wbPort       writeBack;

	// Program words in address order
	word         instrTab [`IMEM_DEPTH];
	int          rowCount;
	// Expected write-backs with twelve ASCII characters of name each
	logic [95:0] expName [`IMEM_DEPTH];
	regIndex     expReg [`IMEM_DEPTH];
	word         expValue [`IMEM_DEPTH];
	int          expCount;

	int          retired;
	int          checkErrors;
	int          otherErrors;
	logic        timedOut;
	int          idle;

	mipsPipeline mipsPipeline_inst (
		.clk(clk),
		.reset(reset),
		.run(run),
		.loadProgram(loadProgram),
		.programAddress(programAddress),
		.programInstruction(programInstruction),
		.writeInstruction(writeInstruction),
		.writeBack(writeBack)
	);

	writeBackChecker wbCheck (
		.clk(clk),
		.reset(reset),
		.writeBack(writeBack),
		.expCount(expCount),
		.expName(expName),
		.expReg(expReg),
		.expValue(expValue),
		.retired(retired),
		.errors(checkErrors)
	);

	// 40 ns clock
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Instruction encoders
	function automatic word rFormat(input logic [5:0] funct, input regIndex rs,
		input regIndex rt, input regIndex rd);
		return {`OP_RTYPE, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic word iFormat(input logic [5:0] op, input regIndex rs,
		input regIndex rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word jFormat(input logic [25:0] index);
		return {`OP_J, index};
	endfunction

	// One program row plus its expected result when hasWb is set
	task automatic addRow(input logic [95:0] name, input word instr, input logic hasWb,
		input regIndex rd, input word value);
		instrTab[rowCount] = instr;
		rowCount++;
		if (hasWb) begin
			expName[expCount] = name;
			expReg[expCount] = rd;
			expValue[expCount] = value;
			expCount++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Program with hand-computed results
	task automatic buildProgram();
		// Dependent chain forwarding from MEM and WB
		addRow("addi", iFormat(`OP_ADDI, 5'd0, 5'd1, 16'd5), 1'b1, 5'd1, 32'd5);
		addRow("addi_fwd", iFormat(`OP_ADDI, 5'd1, 5'd2, 16'd3), 1'b1, 5'd2, 32'd8);
		addRow("add", rFormat(`FN_ADD, 5'd1, 5'd2, 5'd3), 1'b1, 5'd3, 32'd13);
		addRow("sub", rFormat(`FN_SUB, 5'd3, 5'd1, 5'd4), 1'b1, 5'd4, 32'd8);
		addRow("and", rFormat(`FN_AND, 5'd4, 5'd3, 5'd5), 1'b1, 5'd5, 32'd8);
		addRow("or", rFormat(`FN_OR, 5'd5, 5'd1, 5'd6), 1'b1, 5'd6, 32'd13);
		addRow("slt", rFormat(`FN_SLT, 5'd1, 5'd6, 5'd7), 1'b1, 5'd7, 32'd1);
		// Store then load the same word
		addRow("sw", iFormat(`OP_SW, 5'd0, 5'd6, 16'd8), 1'b0, 5'd0, 32'd0);
		addRow("lw", iFormat(`OP_LW, 5'd0, 5'd8, 16'd8), 1'b1, 5'd8, 32'd13);
		// Load-use pair costs one bubble
		addRow("load_use", rFormat(`FN_ADD, 5'd8, 5'd1, 5'd9), 1'b1, 5'd9, 32'd18);
		// Taken BEQ skips two
		addRow("beq", iFormat(`OP_BEQ, 5'd1, 5'd1, 16'd2), 1'b0, 5'd0, 32'd0);
		addRow("beq_skip1", iFormat(`OP_ADDI, 5'd0, 5'd10, 16'd99), 1'b0, 5'd0, 32'd0);
		addRow("beq_skip2", iFormat(`OP_ADDI, 5'd0, 5'd11, 16'd99), 1'b0, 5'd0, 32'd0);
		// BNE falls through on equal operands
		addRow("bne", iFormat(`OP_BNE, 5'd4, 5'd5, 16'd2), 1'b0, 5'd0, 32'd0);
		addRow("bne_next", iFormat(`OP_ADDI, 5'd9, 5'd12, 16'd1), 1'b1, 5'd12, 32'd19);
		addRow("j", jFormat(26'd17), 1'b0, 5'd0, 32'd0);
		addRow("j_skip", iFormat(`OP_ADDI, 5'd0, 5'd13, 16'd99), 1'b0, 5'd0, 32'd0);
		addRow("r0_write", iFormat(`OP_ADDI, 5'd0, 5'd0, 16'd7), 1'b0, 5'd0, 32'd0);
		addRow("r0_read", rFormat(`FN_ADD, 5'd0, 5'd1, 5'd14), 1'b1, 5'd14, 32'd5);
		// Park on a self loop
		addRow("halt", jFormat(26'd19), 1'b0, 5'd0, 32'd0);
	endtask

	// Wait for a write-back count for at most 2000 cycles
	task automatic waitForRetired(input int target);
		int cycles;
		cycles = 0;
		timedOut = 1'b0;
		while (retired < target && !timedOut) begin
			@(posedge clk);
			cycles++;
			if (cycles >= 2000) begin
				timedOut = 1'b1;
			end
		end
		if (timedOut) begin
			$display("Timed out after 2000 cycles with %0d of %0d write-backs seen",
				retired, target);
			otherErrors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reset, load, run and report
	initial begin
		void'($urandom(39));
		reset <= 1'b1;
		run <= 1'b0;
		loadProgram <= 1'b0;
		programAddress <= '0;
		programInstruction <= '0;
		writeInstruction <= 1'b0;
		rowCount = 0;
		expCount = 0;
		otherErrors = 0;
		buildProgram();
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		loadProgram <= 1'b1;
		// One strobe per row with random idle gaps
		for (int i = 0; i < rowCount; i++) begin
			idle = $urandom_range(2, 0);
			@(posedge clk);
			programAddress <= word'(i * 4);
			programInstruction <= instrTab[i];
			writeInstruction <= 1'b1;
			@(posedge clk);
			writeInstruction <= 1'b0;
			repeat (idle) @(posedge clk);
		end
		@(posedge clk);
		loadProgram <= 1'b0;
		@(posedge clk);
		run <= 1'b1;
		// Freeze mid-program for a few cycles
		waitForRetired(5);
		idle = $urandom_range(8, 3);
		run <= 1'b0;
		repeat (idle) @(posedge clk);
		run <= 1'b1;
		waitForRetired(expCount);
		// Drain so extra write-backs still show up
		repeat (20) @(posedge clk);
		$display("Errors: %0d in write-back checks, %0d other; write-backs seen %0d of %0d",
			checkErrors, otherErrors, retired, expCount);
		if (checkErrors == 0 && otherErrors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* tests/writeBackChecker.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module writeBackChecker (
	input  logic             clk,
	input  logic             reset,
	input  mipsPkg::wbPort   writeBack,
	// Expected write-backs in retire order
	input  int               expCount,
	input  logic [95:0]      expName [`IMEM_DEPTH],
	input  mipsPkg::regIndex expReg [`IMEM_DEPTH],
	input  mipsPkg::word     expValue [`IMEM_DEPTH],
	// Running totals for the testbench
	output int               retired,
	output int               errors
);
	import mipsPkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Compare each retired register write
	// Strobe sampled at the edge that writes the register file
	always @(posedge clk) begin
		if (reset) begin
			retired <= 0;
			errors <= 0;
		end else if (writeBack.write) begin
			retired <= retired + 1;
			if (retired >= expCount) begin
				// Nothing left in the table
				$display("Extra write-back to r%0d with 0x%08h after all %0d expected results",
					writeBack.regNum, writeBack.value, expCount);
				errors <= errors + 1;
			end else if (writeBack.regNum !== expReg[retired]
				|| writeBack.value !== expValue[retired]) begin
				$display("FAILED %0s: expected r%0d = 0x%08h, actual r%0d = 0x%08h",
					expName[retired], expReg[retired], expValue[retired],
					writeBack.regNum, writeBack.value);
				errors <= errors + 1;
			end
		end
	end

endmodule

/* verilog/mipsPipeline.sv */
`timescale 1ns/1ps

module mipsPipeline (
	input  logic           clk,
	input  logic           reset,
	input  logic           run,
	// Instruction memory load port
	input  logic           loadProgram,
	input  mipsPkg::word   programAddress,
	input  mipsPkg::word   programInstruction,
	input  logic           writeInstruction,
	// Retired register writes
	output mipsPkg::wbPort writeBack
);
	import mipsPkg::*;

	// IF/ID pair
	word     instruction;
	word     pcNext;
	// Stage registers
	idExReg  idEx;
	exMemReg exMem;
	// Backward paths into fetch
	logic    stall;
	logic    jumpTaken;
	word     jumpTarget;
	logic    branchTaken;
	word     branchTarget;

	instructionFetch ifetch0 (
		.clk(clk),
		.reset(reset),
		.run(run),
		.loadProgram(loadProgram),
		.programAddress(programAddress),
		.programInstruction(programInstruction),
		.writeInstruction(writeInstruction),
		.stall(stall),
		.jumpTaken(jumpTaken),
		.jumpTarget(jumpTarget),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.instruction(instruction),
		.pcNext(pcNext)
	);

	// A taken branch also flushes decode
	instructionDecode idecode0 (
		.clk(clk),
		.reset(reset),
		.run(run),
		.instruction(instruction),
		.pcNext(pcNext),
		.writeBack(writeBack),
		.flush(branchTaken),
		.stall(stall),
		.jumpTaken(jumpTaken),
		.jumpTarget(jumpTarget),
		.idEx(idEx)
	);

	execute execute0 (
		.clk(clk),
		.reset(reset),
		.run(run),
		.idEx(idEx),
		.writeBack(writeBack),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.exMem(exMem)
	);

	memoryAccess memaccess0 (
		.clk(clk),
		.reset(reset),
		.run(run),
		.exMem(exMem),
		.writeBack(writeBack)
	);

endmodule

/* verilog/memoryAccess.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module memoryAccess (
	input  logic             clk,
	input  logic             reset,
	input  logic             run,
	input  mipsPkg::exMemReg exMem,
	output mipsPkg::wbPort   writeBack
);
	import mipsPkg::*;

	localparam int dmemBits = $clog2(`DMEM_DEPTH);

	logic [dmemBits-1:0] wordAddr;
	memWbReg             memWb;
	word                 dataMem [`DMEM_DEPTH];

	// Word addressed, low two bits ignored
	assign wordAddr = exMem.aluResult[dmemBits+1:2];

	////////////////////////////////////////////////////////////////////////////
	// Data memory and MEM/WB register
	// Synchronous read lands in the MEM/WB register
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `DMEM_DEPTH; i++) begin
				dataMem[i] <= '0;
			end
			memWb <= '0;
		end else if (run) begin
			if (exMem.ctrl.memWrite) begin
				dataMem[wordAddr] <= exMem.storeData;
			end
			memWb.regWrite <= exMem.ctrl.regWrite;
			memWb.loadData <= dataMem[wordAddr];
			memWb.aluResult <= exMem.aluResult;
			memWb.memRead <= exMem.ctrl.memRead;
			memWb.rd <= exMem.rd;
		end
	end

	// Write-back select
	// Strobe only in cycles where the pipeline advances
	always_comb begin
		writeBack.write = memWb.regWrite && run && memWb.rd != '0;
		writeBack.regNum = memWb.rd;
		writeBack.value = memWb.memRead ? memWb.loadData : memWb.aluResult;
	end

endmodule

/* verilog/execute.sv */
`timescale 1ns/1ps

module execute (
	input  logic             clk,
	input  logic             reset,
	input  logic             run,
	input  mipsPkg::idExReg  idEx,
	input  mipsPkg::wbPort   writeBack,
	output logic             branchTaken,
	output mipsPkg::word     branchTarget,
	output mipsPkg::exMemReg exMem
);
	import mipsPkg::*;

	word  opA;
	word  fwdB;
	word  opB;
	word  aluResult;
	logic equal;

	// Newest value first, memory stage then write-back
	function automatic word forward(input regIndex src, input word decoded);
		if (src == '0) begin
			return decoded;
		end
		if (exMem.ctrl.regWrite && exMem.rd == src) begin
			return exMem.aluResult;
		end
		if (writeBack.write && writeBack.regNum == src) begin
			return writeBack.value;
		end
		return decoded;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Operand select
	always_comb begin
		opA = forward(idEx.rs, idEx.regA);
		fwdB = forward(idEx.rt, idEx.regB);
	end

	// Immediate for ADDI and address calculation
	assign opB = idEx.ctrl.aluSrcImm ? idEx.immediate : fwdB;

	// ALU
	always_comb begin
		case (idEx.ctrl.aluCode)
			aluSub: aluResult = opA - opB;
			aluAnd: aluResult = opA & opB;
			aluOr:  aluResult = opA | opB;
			aluSlt: aluResult = word'($signed(opA) < $signed(opB));
			default: aluResult = opA + opB;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Branch resolution
	// Compare uses forwarded registers, never the immediate
	assign equal = (opA == fwdB);
	assign branchTaken = (idEx.ctrl.branchEq && equal) || (idEx.ctrl.branchNe && !equal);
	// Word offset relative to the delay slot address
	assign branchTarget = idEx.pcPlusFour + (idEx.immediate << 2);

	// EX/MEM register
	always_ff @(posedge clk) begin
		if (reset) begin
			exMem <= '0;
		end else if (run) begin
			exMem.ctrl <= idEx.ctrl;
			exMem.aluResult <= aluResult;
			// Store data after forwarding
			exMem.storeData <= fwdB;
			exMem.rd <= idEx.rd;
		end
	end

endmodule

/* verilog/instructionDecode.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module instructionDecode (
	input  logic            clk,
	input  logic            reset,
	input  logic            run,
	input  mipsPkg::word    instruction,
	input  mipsPkg::word    pcNext,
	input  mipsPkg::wbPort  writeBack,
	// Taken branch in execute
	input  logic            flush,
	output logic            stall,
	output logic            jumpTaken,
	output mipsPkg::word    jumpTarget,
	output mipsPkg::idExReg idEx
);
	import mipsPkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	regIndex    rs;
	regIndex    rt;
	regIndex    rd;
	regIndex    dest;
	word        immediate;
	word        readA;
	word        readB;
	logic       usesRs;
	logic       usesRt;
	ctrlBits    ctrl;
	word        regFile [32];

	// Instruction fields
	assign opcode = instruction[31:26];
	assign rs = instruction[25:21];
	assign rt = instruction[20:16];
	assign rd = instruction[15:11];
	assign funct = instruction[5:0];
	assign immediate = {{(`DATA_WIDTH-16){instruction[15]}}, instruction[15:0]};

	////////////////////////////////////////////////////////////////////////////
	// Register file
	// Write strobe never targets register zero, so it stays zero
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regFile[i] <= '0;
			end
		end else if (writeBack.write) begin
			regFile[writeBack.regNum] <= writeBack.value;
		end
	end

	// Same-cycle write bypassed to the read
	assign readA = (writeBack.write && writeBack.regNum == rs) ? writeBack.value : regFile[rs];
	assign readB = (writeBack.write && writeBack.regNum == rt) ? writeBack.value : regFile[rt];

	////////////////////////////////////////////////////////////////////////////
	// Control decode
	always_comb begin
		ctrl = '0;
		ctrl.aluCode = aluAdd;
		dest = rt;
		usesRs = 1'b1;
		usesRt = 1'b0;
		jumpTaken = 1'b0;
		case (opcode)
			`OP_RTYPE: begin
				dest = rd;
				usesRt = 1'b1;
				ctrl.regWrite = 1'b1;
				case (funct)
					`FN_ADD: ctrl.aluCode = aluAdd;
					`FN_SUB: ctrl.aluCode = aluSub;
					`FN_AND: ctrl.aluCode = aluAnd;
					`FN_OR:  ctrl.aluCode = aluOr;
					`FN_SLT: ctrl.aluCode = aluSlt;
					// Unknown function, all-zero word included, is a NOP
					default: ctrl.regWrite = 1'b0;
				endcase
			end
			`OP_ADDI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			`OP_LW: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			`OP_SW: begin
				usesRt = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			`OP_BEQ: begin
				usesRt = 1'b1;
				ctrl.branchEq = 1'b1;
				ctrl.aluCode = aluSub;
			end
			`OP_BNE: begin
				usesRt = 1'b1;
				ctrl.branchNe = 1'b1;
				ctrl.aluCode = aluSub;
			end
			`OP_J: begin
				usesRs = 1'b0;
				jumpTaken = 1'b1;
			end
			default: usesRs = 1'b0;
		endcase
	end

	// Jump region comes from the upper PC bits
	assign jumpTarget = {pcNext[31:28], instruction[25:0], 2'b00};

	// Load in execute feeding this instruction
	assign stall = idEx.ctrl.memRead && idEx.rt != '0
		&& ((usesRs && idEx.rt == rs) || (usesRt && idEx.rt == rt));

	////////////////////////////////////////////////////////////////////////////
	// ID/EX register
	// Bubble on flush or load-use stall
	always_ff @(posedge clk) begin
		if (reset) begin
			idEx <= '0;
		end else if (run) begin
			if (flush || stall) begin
				idEx <= '0;
			end else begin
				idEx.ctrl <= ctrl;
				idEx.pcPlusFour <= pcNext;
				idEx.regA <= readA;
				idEx.regB <= readB;
				idEx.immediate <= immediate;
				idEx.rs <= rs;
				idEx.rt <= rt;
				idEx.rd <= dest;
			end
		end
	end

endmodule

/* verilog/instructionFetch.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module instructionFetch (
	input  logic         clk,
	input  logic         reset,
	input  logic         run,
	// Program load port, byte address like the PC
	input  logic         loadProgram,
	input  mipsPkg::word programAddress,
	input  mipsPkg::word programInstruction,
	input  logic         writeInstruction,
	// Hazard hold and redirects
	input  logic         stall,
	input  logic         jumpTaken,
	input  mipsPkg::word jumpTarget,
	input  logic         branchTaken,
	input  mipsPkg::word branchTarget,
	// IF/ID register
	output mipsPkg::word instruction,
	output mipsPkg::word pcNext
);
	import mipsPkg::*;

	localparam int imemBits = $clog2(`IMEM_DEPTH);

	word pc;
	word pcPlusFour;
	word fetched;
	word instrMem [`IMEM_DEPTH];

	assign pcPlusFour = pc + word'(4);
	// Word index from the byte address
	assign fetched = instrMem[pc[imemBits+1:2]];

	// One word per write strobe while loading
	always_ff @(posedge clk) begin
		if (loadProgram && writeInstruction) begin
			instrMem[programAddress[imemBits+1:2]] <= programInstruction;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Program counter
	// Branch from execute wins over jump from decode
	always_ff @(posedge clk) begin
		if (reset || loadProgram) begin
			pc <= '0;
		end else if (run) begin
			if (branchTaken) begin
				pc <= branchTarget;
			end else if (jumpTaken) begin
				pc <= jumpTarget;
			end else if (!stall) begin
				pc <= pcPlusFour;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// IF/ID register
	// Cleared to a NOP on any redirect, held on stall
	always_ff @(posedge clk) begin
		if (reset) begin
			instruction <= '0;
			pcNext <= '0;
		end else if (run) begin
			if (branchTaken || jumpTaken) begin
				instruction <= '0;
				pcNext <= '0;
			end else if (!stall) begin
				instruction <= fetched;
				pcNext <= pcPlusFour;
			end
		end
	end

endmodule

/* verilog/mipsPkg.sv */
`include "mips_consts.svh"

package mipsPkg;

	// Data, addresses and instructions
	typedef logic [`DATA_WIDTH-1:0] word;

	// Register number
	typedef logic [4:0] regIndex;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt
	} aluOp;

	// WB, MEM and EX control groups in one word
	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic aluSrcImm;
		logic branchEq;
		logic branchNe;
		aluOp aluCode;
	} ctrlBits;

	typedef struct packed {
		ctrlBits ctrl;
		word     pcPlusFour;
		word     regA;
		word     regB;
		word     immediate;
		regIndex rs;
		regIndex rt;
		// Destination, rd for R-type and rt otherwise
		regIndex rd;
	} idExReg;

	typedef struct packed {
		ctrlBits ctrl;
		word     aluResult;
		word     storeData;
		regIndex rd;
	} exMemReg;

	typedef struct packed {
		logic    regWrite;
		word     loadData;
		word     aluResult;
		logic    memRead;
		regIndex rd;
	} memWbReg;

	// Register file write, also used for forwarding
	typedef struct packed {
		logic    write;
		regIndex regNum;
		word     value;
	} wbPort;

endpackage

/* verilog/mips_consts.svh */
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// Machine word
`define DATA_WIDTH 32

// Memory sizes in words
`define IMEM_DEPTH 64
`define DMEM_DEPTH 64

// Opcodes, instruction bits 31:26
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDI  6'h08
`define OP_LW    6'h23
`define OP_SW    6'h2b

// R-type function codes, instruction bits 5:0
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_OR  6'h25
`define FN_SLT 6'h2a

`endif
